/* hdl/aud_config.svh */
`ifndef AUD_CONFIG_SVH
`define AUD_CONFIG_SVH

// One audio word per frame, left channel only
`define AUD_SAMPLE_W 16

// 64 words keeps simulation short, larger values work too
`define AUD_ADDR_W 6

`define AUD_DEPTH (1 << `AUD_ADDR_W)

`endif

/* hdl/aud_pkg.sv */
`include "aud_config.svh"

package aud_pkg;

    typedef logic [`AUD_SAMPLE_W-1:0] sample_t;

    // RAM word address
    typedef logic [`AUD_ADDR_W-1:0] addr_t;

    // Word count from 0 up to a full RAM
    typedef logic [`AUD_ADDR_W:0] len_t;

    // Shared by recorder and player
    typedef enum logic [2:0] {
        S_IDLE,
        S_WAIT,
        S_XFER,
        S_PAUSE,
        S_FINISH
    } eng_state_e;

    typedef enum logic [1:0] {
        MODE_IDLE,
        MODE_REC,
        MODE_PLAY
    } aud_mode_e;

endpackage

/* hdl/aud_mem_if.sv */
`timescale 1ns/100ps

interface aud_mem_if import aud_pkg::*; ();

    logic    wr_en;
    addr_t   wr_addr;
    sample_t wr_data;
    addr_t   rd_addr;
    // Valid one cycle after rd_addr
    sample_t rd_data;

    modport writer (
        output wr_en, wr_addr, wr_data
    );

    modport reader (
        output rd_addr,
        input  rd_data
    );

    modport ram (
        input  wr_en, wr_addr, wr_data, rd_addr,
        output rd_data
    );

endinterface

/* hdl/aud_ctl_if.sv */
`timescale 1ns/100ps

interface aud_ctl_if import aud_pkg::*; ();

    // One-cycle command pulses from the register block
    logic rec_start;
    logic play_start;
    logic pause;
    logic stop;

    // One-cycle completion pulses, rec_len valid with rec_done
    logic rec_done;
    logic play_done;
    len_t rec_len;

    modport ctrl (
        output rec_start, play_start, pause, stop,
        input  rec_done, play_done, rec_len
    );

    modport rec (
        input  rec_start, pause, stop,
        output rec_done, rec_len
    );

    modport play (
        input  play_start, pause, stop,
        output play_done
    );

endinterface

/* hdl/aud_sample_ram.sv */
`timescale 1ns/100ps
`include "aud_config.svh"

module aud_sample_ram import aud_pkg::*; (
    input  logic  i_clk,
    aud_mem_if.ram mem
);

    sample_t ram_q [`AUD_DEPTH];
    sample_t rd_data_r;

    always_ff @(negedge i_clk) begin
        if (mem.wr_en) begin
            ram_q[mem.wr_addr] <= mem.wr_data;
        end
    end

    // Registered read, old data on a same-address write
    always_ff @(negedge i_clk) begin
        rd_data_r <= ram_q[mem.rd_addr];
    end

    assign mem.rd_data = rd_data_r;

endmodule

/* hdl/aud_ctrl_regs.sv */
`timescale 1ns/100ps

module aud_ctrl_regs import aud_pkg::*; (
    input  logic      i_clk,
    input  logic      i_rst_n,
    input  logic      i_start_rec,
    input  logic      i_start_play,
    input  logic      i_pause,
    input  logic      i_stop,
    aud_ctl_if.ctrl   ctl,
    output aud_mode_e o_mode,
    output logic      o_busy,
    output len_t      o_rec_len
);

    aud_mode_e mode_r;
    len_t      len_r;
    logic      rec_start_r;
    logic      play_start_r;
    logic      pause_r;
    logic      stop_r;
    logic      idle;
    logic      rec_ok;
    logic      play_ok;

    assign idle    = (mode_r == MODE_IDLE);
    assign rec_ok  = idle && i_start_rec;
    // Record wins a tie, and nothing to play after an empty take
    assign play_ok = idle && i_start_play && !i_start_rec && (len_r != '0);

    always_ff @(negedge i_clk) begin
        if (i_rst_n) begin
            mode_r       <= MODE_IDLE;
            len_r        <= '0;
            rec_start_r  <= 1'b0;
            play_start_r <= 1'b0;
            pause_r      <= 1'b0;
            stop_r       <= 1'b0;
        end else begin
            rec_start_r  <= rec_ok;
            play_start_r <= play_ok;
            pause_r      <= i_pause && !idle;
            stop_r       <= i_stop && !idle;
            if (ctl.rec_done) begin
                len_r <= ctl.rec_len;
            end
            if (ctl.rec_done || ctl.play_done) begin
                mode_r <= MODE_IDLE;
            end else if (rec_ok) begin
                mode_r <= MODE_REC;
            end else if (play_ok) begin
                mode_r <= MODE_PLAY;
            end
        end
    end

    assign ctl.rec_start  = rec_start_r;
    assign ctl.play_start = play_start_r;
    assign ctl.pause      = pause_r;
    assign ctl.stop       = stop_r;

    assign o_mode    = mode_r;
    assign o_busy    = !idle;
    assign o_rec_len = len_r;

endmodule

/* hdl/aud_recorder.sv */
`timescale 1ns/100ps
`include "aud_config.svh"

module aud_recorder import aud_pkg::*; (
    input  logic      i_clk,
    input  logic      i_rst_n,
    input  logic      i_lrc,
    input  logic      i_adc_data,
    aud_ctl_if.rec    ctl,
    aud_mem_if.writer mem
);

    localparam int BIT_W = $clog2(`AUD_SAMPLE_W + 1);

    eng_state_e       state_r, state_w;
    len_t             count_r, count_w;
    sample_t          data_r, data_w;
    logic [BIT_W-1:0] bit_r, bit_w;
    logic             wait_high_r, wait_high_w;
    logic             from_xfer_r, from_xfer_w;
    logic             word_end;

    // All 16 bits in, store on this edge
    assign word_end = (state_r == S_XFER) && (bit_r == BIT_W'(`AUD_SAMPLE_W));

    assign mem.wr_en    = word_end;
    assign mem.wr_addr  = count_r[`AUD_ADDR_W-1:0];
    assign mem.wr_data  = data_r;
    assign ctl.rec_done = (state_r == S_FINISH);
    assign ctl.rec_len  = count_r;

    always_comb begin
        state_w     = state_r;
        count_w     = count_r;
        data_w      = data_r;
        bit_w       = bit_r;
        wait_high_w = wait_high_r;
        from_xfer_w = from_xfer_r;
        case (state_r)
            S_IDLE: begin
                if (ctl.rec_start) begin
                    state_w     = S_WAIT;
                    count_w     = '0;
                    bit_w       = '0;
                    wait_high_w = 1'b0;
                end
            end
            S_WAIT: begin
                if (ctl.stop) begin
                    state_w = S_FINISH;
                end else if (ctl.pause) begin
                    state_w     = S_PAUSE;
                    from_xfer_w = 1'b0;
                end else if (i_lrc) begin
                    wait_high_w = 1'b0;
                end else if (!wait_high_r) begin
                    // Delay bit edge
                    state_w = S_XFER;
                    bit_w   = '0;
                end
            end
            S_XFER: begin
                if (word_end) begin
                    count_w     = count_r + 1'b1;
                    bit_w       = '0;
                    wait_high_w = 1'b1;
                    if (ctl.stop || count_w == len_t'(`AUD_DEPTH)) begin
                        state_w = S_FINISH;
                    end else if (ctl.pause) begin
                        state_w     = S_PAUSE;
                        from_xfer_w = 1'b0;
                    end else begin
                        state_w = S_WAIT;
                    end
                end else if (ctl.stop) begin
                    // Partial word is dropped
                    state_w = S_FINISH;
                end else if (ctl.pause) begin
                    state_w     = S_PAUSE;
                    from_xfer_w = 1'b1;
                end else if (i_lrc) begin
                    bit_w   = '0;
                    state_w = S_WAIT;
                end else begin
                    data_w = {data_r[`AUD_SAMPLE_W-2:0], i_adc_data};
                    bit_w  = bit_r + 1'b1;
                end
            end
            S_PAUSE: begin
                if (ctl.stop) begin
                    state_w = S_FINISH;
                end else if (ctl.pause) begin
                    wait_high_w = 1'b1;
                    if (from_xfer_r) begin
                        state_w = S_XFER;
                    end else begin
                        state_w = S_WAIT;
                    end
                end
            end
            S_FINISH: begin
                state_w = S_IDLE;
            end
            default: begin
                state_w = S_IDLE;
            end
        endcase
    end

    always_ff @(negedge i_clk) begin
        if (i_rst_n) begin
            state_r     <= S_IDLE;
            count_r     <= '0;
            bit_r       <= '0;
            wait_high_r <= 1'b0;
            from_xfer_r <= 1'b0;
        end else begin
            state_r     <= state_w;
            count_r     <= count_w;
            bit_r       <= bit_w;
            wait_high_r <= wait_high_w;
            from_xfer_r <= from_xfer_w;
        end
    end

    always_ff @(negedge i_clk) begin
        data_r <= data_w;
    end

endmodule

/* hdl/aud_player.sv */
`timescale 1ns/100ps
`include "aud_config.svh"

module aud_player import aud_pkg::*; (
    input  logic      i_clk,
    input  logic      i_rst_n,
    input  logic      i_lrc,
    output logic      o_dac_data,
    aud_ctl_if.play   ctl,
    aud_mem_if.reader mem,
    input  len_t      i_play_len
);

    localparam int BIT_W = $clog2(`AUD_SAMPLE_W + 1);

    eng_state_e       state_r, state_w;
    len_t             count_r, count_w;
    sample_t          shift_r, shift_w;
    logic [BIT_W-1:0] bit_r, bit_w;
    logic             wait_high_r, wait_high_w;
    logic             from_xfer_r, from_xfer_w;
    logic             dac_r, dac_w;

    // Read address sits on the next word, so rd_data is ready by the delay bit
    assign mem.rd_addr   = count_r[`AUD_ADDR_W-1:0];
    assign ctl.play_done = (state_r == S_FINISH);
    assign o_dac_data    = dac_r;

    always_comb begin
        state_w     = state_r;
        count_w     = count_r;
        shift_w     = shift_r;
        bit_w       = bit_r;
        wait_high_w = wait_high_r;
        from_xfer_w = from_xfer_r;
        dac_w       = 1'b0;
        case (state_r)
            S_IDLE: begin
                if (ctl.play_start) begin
                    state_w     = S_WAIT;
                    count_w     = '0;
                    wait_high_w = 1'b0;
                end
            end
            S_WAIT: begin
                if (ctl.stop) begin
                    state_w = S_FINISH;
                end else if (ctl.pause) begin
                    state_w     = S_PAUSE;
                    from_xfer_w = 1'b0;
                end else if (i_lrc) begin
                    wait_high_w = 1'b0;
                end else if (!wait_high_r) begin
                    state_w = S_XFER;
                    bit_w   = '0;
                    shift_w = mem.rd_data;
                end
            end
            S_XFER: begin
                if (bit_r == BIT_W'(`AUD_SAMPLE_W)) begin
                    count_w     = count_r + 1'b1;
                    wait_high_w = 1'b1;
                    if (ctl.stop || count_w == i_play_len) begin
                        state_w = S_FINISH;
                    end else if (ctl.pause) begin
                        state_w     = S_PAUSE;
                        from_xfer_w = 1'b0;
                    end else begin
                        state_w = S_WAIT;
                    end
                end else if (ctl.stop) begin
                    state_w = S_FINISH;
                end else if (ctl.pause) begin
                    state_w     = S_PAUSE;
                    from_xfer_w = 1'b1;
                end else begin
                    dac_w   = shift_r[`AUD_SAMPLE_W-1];
                    shift_w = {shift_r[`AUD_SAMPLE_W-2:0], 1'b0};
                    bit_w   = bit_r + 1'b1;
                end
            end
            S_PAUSE: begin
                if (ctl.stop) begin
                    state_w = S_FINISH;
                end else if (ctl.pause) begin
                    wait_high_w = 1'b1;
                    if (from_xfer_r) begin
                        state_w = S_XFER;
                    end else begin
                        state_w = S_WAIT;
                    end
                end
            end
            default: begin
                // Park the read address on word 0 for the next start
                state_w = S_IDLE;
                count_w = '0;
            end
        endcase
    end

    always_ff @(negedge i_clk) begin
        if (i_rst_n) begin
            state_r     <= S_IDLE;
            count_r     <= '0;
            bit_r       <= '0;
            wait_high_r <= 1'b0;
            from_xfer_r <= 1'b0;
            dac_r       <= 1'b0;
        end else begin
            state_r     <= state_w;
            count_r     <= count_w;
            bit_r       <= bit_w;
            wait_high_r <= wait_high_w;
            from_xfer_r <= from_xfer_w;
            dac_r       <= dac_w;
        end
    end

    always_ff @(negedge i_clk) begin
        shift_r <= shift_w;
    end

endmodule

/* hdl/aud_core_top.sv */
`timescale 1ns/100ps

module aud_core_top import aud_pkg::*; (
    input  logic      i_clk,
    input  logic      i_rst_n,
    input  logic      i_lrc,
    input  logic      i_adc_data,
    input  logic      i_start_rec,
    input  logic      i_start_play,
    input  logic      i_pause,
    input  logic      i_stop,
    output logic      o_dac_data,
    output aud_mode_e o_mode,
    output logic      o_busy,
    output len_t      o_rec_len
);

    aud_mem_if u_mem_if ();
    aud_ctl_if u_ctl_if ();

    aud_ctrl_regs u_ctrl_regs (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_start_rec  (i_start_rec),
        .i_start_play (i_start_play),
        .i_pause      (i_pause),
        .i_stop       (i_stop),
        .ctl          (u_ctl_if.ctrl),
        .o_mode       (o_mode),
        .o_busy       (o_busy),
        .o_rec_len    (o_rec_len)
    );

    aud_recorder u_recorder (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_lrc      (i_lrc),
        .i_adc_data (i_adc_data),
        .ctl        (u_ctl_if.rec),
        .mem        (u_mem_if.writer)
    );

    // Playback length is the stored length from the register block
    aud_player u_player (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_lrc      (i_lrc),
        .o_dac_data (o_dac_data),
        .ctl        (u_ctl_if.play),
        .mem        (u_mem_if.reader),
        .i_play_len (o_rec_len)
    );

    aud_sample_ram u_sample_ram (
        .i_clk (i_clk),
        .mem   (u_mem_if.ram)
    );

endmodule

/* dv/aud_core_tb.sv */
`timescale 1ns/100ps
`include "aud_config.svh"

module aud_core_tb import aud_pkg::*; ();

    localparam int TBL_LEN    = 8;
    localparam int LOW_SLOTS  = 20;
    localparam int HIGH_SLOTS = 20;
    localparam int WAIT_LIMIT = 400;
    localparam int CMD_REC    = 0;
    localparam int CMD_PLAY   = 1;
    localparam int CMD_PAUSE  = 2;
    localparam int CMD_STOP   = 3;

    logic      i_clk;
    logic      i_rst_n;
    logic      i_lrc;
    logic      i_adc_data;
    logic      i_start_rec;
    logic      i_start_play;
    logic      i_pause;
    logic      i_stop;
    logic      o_dac_data;
    aud_mode_e o_mode;
    logic      o_busy;
    len_t      o_rec_len;

    // One sample and a pause-before flag per frame
    sample_t tbl_data [TBL_LEN];
    logic    tbl_pause [TBL_LEN];

    sample_t exp_q [$];
    sample_t dac_q [$];
    logic    mon_en;
    int      low_cnt;
    sample_t mon_word;

    aud_core_top u_dut (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_lrc        (i_lrc),
        .i_adc_data   (i_adc_data),
        .i_start_rec  (i_start_rec),
        .i_start_play (i_start_play),
        .i_pause      (i_pause),
        .i_stop       (i_stop),
        .o_dac_data   (o_dac_data),
        .o_mode       (o_mode),
        .o_busy       (o_busy),
        .o_rec_len    (o_rec_len)
    );

    always #10 i_clk = ~i_clk;

    // DAC monitor, slot 0 of the low half is the delay bit
    always @(posedge i_clk) begin
        if (!mon_en || i_lrc) begin
            low_cnt = 0;
        end else begin
            if (low_cnt >= 1 && low_cnt <= `AUD_SAMPLE_W) begin
                mon_word = {mon_word[`AUD_SAMPLE_W-2:0], o_dac_data};
            end
            if (low_cnt == `AUD_SAMPLE_W) begin
                dac_q.push_back(mon_word);
            end
            low_cnt = low_cnt + 1;
        end
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("=== FAIL ===");
        $fatal(1);
    endtask

    task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp));
        end
    endtask

    task automatic pulse_cmd(input int cmd);
        @(posedge i_clk);
        case (cmd)
            CMD_REC:   i_start_rec  <= 1'b1;
            CMD_PLAY:  i_start_play <= 1'b1;
            CMD_PAUSE: i_pause      <= 1'b1;
            default:   i_stop       <= 1'b1;
        endcase
        @(posedge i_clk);
        i_start_rec  <= 1'b0;
        i_start_play <= 1'b0;
        i_pause      <= 1'b0;
        i_stop       <= 1'b0;
        // Command reaches the engine one cycle after the register block
        repeat (3) @(posedge i_clk);
    endtask

    // I2S frame, low half then high half, filler bits are random
    task automatic send_frame(input sample_t word);
        for (int i = 0; i < LOW_SLOTS; i++) begin
            @(posedge i_clk);
            i_lrc <= 1'b0;
            if (i >= 1 && i <= `AUD_SAMPLE_W) begin
                i_adc_data <= word[`AUD_SAMPLE_W-i];
            end else begin
                i_adc_data <= 1'($urandom);
            end
        end
        for (int i = 0; i < HIGH_SLOTS; i++) begin
            @(posedge i_clk);
            i_lrc      <= 1'b1;
            i_adc_data <= 1'($urandom);
        end
    endtask

    task automatic wait_idle(input string what);
        int n;
        n = 0;
        while (o_busy !== 1'b0) begin
            if (n == WAIT_LIMIT) begin
                fail_run($sformatf("Timed out waiting for the core to go idle after %s", what));
            end
            @(posedge i_clk);
            n++;
        end
    endtask

    task automatic record_table(input logic use_pause);
        logic paused;
        paused = 1'b0;
        exp_q.delete();
        pulse_cmd(CMD_REC);
        check_eq("o_mode", o_mode, MODE_REC);
        for (int i = 0; i < TBL_LEN; i++) begin
            if (use_pause && tbl_pause[i]) begin
                pulse_cmd(CMD_PAUSE);
                paused = !paused;
            end
            if (use_pause && i == 1) begin
                // Start of playback is refused while recording
                pulse_cmd(CMD_PLAY);
                check_eq("o_mode", o_mode, MODE_REC);
            end
            send_frame(tbl_data[i]);
            if (!paused) begin
                exp_q.push_back(tbl_data[i]);
            end
        end
        pulse_cmd(CMD_STOP);
        wait_idle("stop");
        check_eq("o_rec_len", o_rec_len, exp_q.size());
    endtask

    task automatic play_check();
        int frames;
        frames = 0;
        dac_q.delete();
        mon_en = 1'b1;
        pulse_cmd(CMD_PLAY);
        check_eq("o_mode", o_mode, MODE_PLAY);
        while (o_mode == MODE_PLAY) begin
            if (frames > `AUD_DEPTH) begin
                fail_run("Playback kept running past a full memory of frames");
            end
            send_frame(sample_t'($urandom));
            frames++;
        end
        mon_en = 1'b0;
        check_eq("played_frames", frames, exp_q.size());
        check_eq("dac_word_count", dac_q.size(), exp_q.size());
        foreach (exp_q[i]) begin
            check_eq("o_dac_data", dac_q[i], exp_q[i]);
        end
    endtask

    initial begin
        void'($urandom(32'h5b29));
        i_clk        = 1'b0;
        i_rst_n      = 1'b1;
        i_lrc        = 1'b1;
        i_adc_data   = 1'b0;
        i_start_rec  = 1'b0;
        i_start_play = 1'b0;
        i_pause      = 1'b0;
        i_stop       = 1'b0;
        mon_en       = 1'b0;
        low_cnt      = 0;
        mon_word     = '0;
        tbl_data[0] = 16'h8001;
        tbl_data[1] = 16'h7ffe;
        tbl_data[2] = 16'hffff;
        tbl_data[3] = 16'h0000;
        tbl_data[4] = 16'ha5a5;
        for (int i = 5; i < TBL_LEN; i++) begin
            tbl_data[i] = sample_t'($urandom);
        end
        // Pause before frame 2, resume before frame 4
        foreach (tbl_pause[i]) begin
            tbl_pause[i] = (i == 2 || i == 4);
        end

        repeat (4) @(posedge i_clk);
        i_rst_n <= 1'b0;
        repeat (2) @(posedge i_clk);
        check_eq("o_mode", o_mode, MODE_IDLE);
        check_eq("o_busy", o_busy, 1'b0);
        check_eq("o_rec_len", o_rec_len, 0);
        check_eq("o_dac_data", o_dac_data, 1'b0);

        // Nothing recorded yet
        pulse_cmd(CMD_PLAY);
        check_eq("o_mode", o_mode, MODE_IDLE);
        check_eq("o_busy", o_busy, 1'b0);

        record_table(1'b0);
        play_check();
        record_table(1'b1);
        play_check();

        // No stop, the recorder ends when the RAM is full
        pulse_cmd(CMD_REC);
        for (int i = 0; i < `AUD_DEPTH + 4; i++) begin
            send_frame(sample_t'($urandom));
        end
        wait_idle("a full memory");
        check_eq("o_rec_len", o_rec_len, `AUD_DEPTH);
        check_eq("o_mode", o_mode, MODE_IDLE);

        $display("=== PASS ===");
        $finish;
    end

endmodule

/* aud_core_top.f */
+incdir+hdl
hdl/aud_pkg.sv
hdl/aud_mem_if.sv
hdl/aud_ctl_if.sv
hdl/aud_sample_ram.sv
hdl/aud_ctrl_regs.sv
hdl/aud_recorder.sv
hdl/aud_player.sv
hdl/aud_core_top.sv
dv/aud_core_tb.sv
